/* filelist.f */
+incdir+include
source/aluDataPkg.sv
source/aluCmdPkg.sv
source/aluIfs.sv
source/commandDecoder.sv
source/operandRegs.sv
source/arithSequencer.sv
source/addSubDatapath.sv
source/modeChangeMonitor.sv
source/aluTop.sv
verif/alu_properties.sv
verif/aluTb.sv

/* Bender.yml */
package:
  name: serial_alu

export_include_dirs:
  - include

sources:
  - files:
      - source/aluDataPkg.sv
      - source/aluCmdPkg.sv
      - source/aluIfs.sv
      - source/commandDecoder.sv
      - source/operandRegs.sv
      - source/arithSequencer.sv
      - source/addSubDatapath.sv
      - source/modeChangeMonitor.sv
      - source/aluTop.sv
  - target: simulation
    files:
      - verif/alu_properties.sv
      - verif/aluTb.sv

/* verif/aluTb.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the serial arithmetic unit
// Stimulus table, stepwise reference model, value checks, watchdog
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module aluTb;
  import aluCmdPkg::*;
  import aluDataPkg::*;

  localparam int clkPeriod     = 10;
  localparam int resetCycles   = 10;
  localparam int numRandom     = 12;
  localparam int numTests      = 16;
  localparam int cyclesPerTest = 64;
  localparam int marginCycles  = 200;
  localparam int doneLimit     = 20;
  localparam longint timeoutNs =
    longint'(resetCycles + numTests * cyclesPerTest + marginCycles) * clkPeriod;

  logic       CLK;
  logic       RST;
  logic [7:0] ctrlIn;
  byte_t      dataIn;
  byte_t      resultOut;
  logic       done;
  logic       overflow;
  logic       negative;
  logic       modeError;

  logic [15:0] lfsrState;

  // One row per test, stimulus then expected results
  aluOp_e tOp     [numTests];
  logic   tSigned [numTests];
  logic   tUseA   [numTests];
  word_t  tA      [numTests];
  word_t  tB      [numTests];
  byte_t  tData   [numTests];
  word_t  expA    [numTests];
  word_t  expB    [numTests];
  logic   expOvf  [numTests];
  logic   expNeg  [numTests];

  aluTop dut (
    .CLK       (CLK),
    .RST       (RST),
    .ctrlIn    (ctrlIn),
    .dataIn    (dataIn),
    .resultOut (resultOut),
    .done      (done),
    .overflow  (overflow),
    .negative  (negative),
    .modeError (modeError)
  );

  always #(clkPeriod / 2) CLK = ~CLK;

  ////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    logic fb;
    // x^16 + x^14 + x^13 + x^11 + 1
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic drawBits(input int n, output logic [15:0] v);
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsrState = lfsrStep(lfsrState);
      v = {v[14:0], lfsrState[0]};
    end
  endtask

  function automatic ctrlWord_u loadWord(input logic sm, input logic regSel,
                                         input logic hiByte, input logic write);
    ctrlWord_u w;
    w = '0;
    w.load.signedMode = sm;
    w.load.op         = opLoad;
    w.load.regSel     = regSel;
    w.load.byteSel    = hiByte;
    w.load.write      = write;
    w.load.start      = 1'b1;
    return w;
  endfunction

  function automatic ctrlWord_u opWord(input aluOp_e op, input logic sm, input logic useA);
    ctrlWord_u w;
    w = '0;
    w.arith.signedMode = sm;
    w.arith.op         = op;
    w.arith.useRegA    = useA;
    w.arith.start      = 1'b1;
    return w;
  endfunction

  task automatic applyCtrl(input logic [7:0] ctrl, input byte_t data);
    @(posedge CLK);
    ctrlIn <= ctrl;
    dataIn <= data;
  endtask

  // Two edges for the input register and the selector, then mid-cycle
  task automatic settle();
    @(posedge CLK);
    @(posedge CLK);
    @(negedge CLK);
  endtask

  task automatic loadByte(input logic regSel, input logic hiByte, input byte_t value);
    applyCtrl(loadWord(1'b0, regSel, hiByte, 1'b1), value);
    applyCtrl(8'h00, 8'h00);
  endtask

  task automatic checkValue(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    if (actual !== expected)
    begin
      $display("Error: %s expected %h actual %h", name, expected, actual);
      $display("Checks failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic readBackAll(input string name, input logic sm, input word_t a,
                             input word_t b, input logic expDone);
    logic [31:0] both;
    both = {b, a};
    for (int sel = 0; sel < 4; sel++)
    begin
      applyCtrl(loadWord(sm, sel[1], sel[0], 1'b0), 8'h00);
      settle();
      checkValue($sformatf("%s byte %0d", name, sel), both[sel*8 +: 8], resultOut);
      checkValue($sformatf("%s done level", name), expDone, done);
    end
  endtask

  task automatic waitDone(input string name);
    int count;
    count = 0;
    while (!done && count < doneLimit)
    begin
      @(negedge CLK);
      count++;
    end
    if (!done)
    begin
      $display("Timeout: done never rose during %s", name);
      $display("Checks failed");
      $fatal(1, "No done from the DUT");
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Reference model, one adder step at a time
  task automatic addSubStep(input word_t b, input word_t x, input logic sub,
                            input logic sm, output word_t res, output logic ovf);
    logic [16:0] wide;
    wide = sub ? ({1'b0, b} - {1'b0, x}) : ({1'b0, b} + {1'b0, x});
    res  = wide[15:0];
    // Bit 16 is the carry, or the borrow when subtracting
    if (sm)
      ovf = ((b[15] ^ sub) == x[15]) && (res[15] != b[15]);
    else
      ovf = wide[16];
  endtask

  task automatic computeExpected(input int i);
    word_t a;
    word_t b;
    word_t operand;
    word_t res;
    logic  stepOvf;
    logic  ovf;
    a   = tA[i];
    b   = tB[i];
    ovf = 1'b0;
    if (tOp[i] == opMul)
    begin
      // Signed data bit 7 weighs minus 128, so that step subtracts
      for (int k = 0; k < 8; k++)
      begin
        operand = tData[i][k] ? a : 16'h0000;
        addSubStep(b, operand, tSigned[i] && k == 7, tSigned[i], res, stepOvf);
        b   = res;
        ovf = ovf | stepOvf;
        a   = a << 1;
      end
    end
    else
    begin
      if (tUseA[i])
        operand = a;
      else if (tSigned[i])
        operand = {{8{tData[i][7]}}, tData[i]};
      else
        operand = {8'h00, tData[i]};
      addSubStep(b, operand, tOp[i] == opSub, tSigned[i], res, stepOvf);
      b   = res;
      ovf = stepOvf;
    end
    expA[i]   = a;
    expB[i]   = b;
    expOvf[i] = ovf;
    expNeg[i] = tSigned[i] & b[15];
  endtask

  task automatic setRow(input int i, input aluOp_e op, input logic sm, input logic useA,
                        input word_t a, input word_t b, input byte_t d);
    tOp[i]     = op;
    tSigned[i] = sm;
    tUseA[i]   = useA;
    tA[i]      = a;
    tB[i]      = b;
    tData[i]   = d;
  endtask

  task automatic buildTable();
    logic [15:0] va;
    logic [15:0] vb;
    logic [15:0] vd;
    // Every op, mode and operand source combination with random values
    for (int i = 0; i < numRandom; i++)
    begin
      drawBits(16, va);
      drawBits(16, vb);
      drawBits(8, vd);
      setRow(i, aluOp_e'(opAdd + i % 3), (i / 3) % 2, (i / 6) % 2, va, vb, vd[7:0]);
    end
    // Carry, signed overflow, borrow, negative multiplier
    setRow(12, opAdd, 1'b0, 1'b1, 16'hFFFF, 16'h0001, 8'h00);
    setRow(13, opAdd, 1'b1, 1'b1, 16'h7FFF, 16'h0001, 8'h00);
    setRow(14, opSub, 1'b0, 1'b0, 16'h1234, 16'h0010, 8'h80);
    setRow(15, opMul, 1'b1, 1'b0, 16'h0100, 16'h0000, 8'h80);
    for (int i = 0; i < numTests; i++)
      computeExpected(i);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Main sequence
  initial
  begin
    string name;
    CLK       = 1'b0;
    RST       = 1'b1;
    ctrlIn    = '0;
    dataIn    = '0;
    lfsrState = 16'd52;
    buildTable();
    repeat (resetCycles) @(posedge CLK);
    RST <= 1'b0;
    @(negedge CLK);
    checkValue("reset flags", 16'h0000, {done, overflow, negative, modeError});
    checkValue("reset result", 16'h0000, resultOut);

    for (int i = 0; i < numTests; i++)
    begin
      name = $sformatf("test %0d", i);
      loadByte(regA, 1'b0, tA[i][7:0]);
      loadByte(regA, 1'b1, tA[i][15:8]);
      loadByte(regB, 1'b0, tB[i][7:0]);
      loadByte(regB, 1'b1, tB[i][15:8]);
      readBackAll({name, " load"}, 1'b0, tA[i], tB[i], 1'b0);
      applyCtrl(8'h00, 8'h00);

      // Start stays high through the read-back, so done must hold
      applyCtrl(opWord(tOp[i], tSigned[i], tUseA[i]), tData[i]);
      waitDone(name);
      checkValue({name, " overflow"}, expOvf[i], overflow);
      checkValue({name, " negative"}, expNeg[i], negative);
      readBackAll({name, " result"}, tSigned[i], expA[i], expB[i], 1'b1);

      applyCtrl(8'h00, 8'h00);
      settle();
      checkValue({name, " done after start drop"}, 1'b0, done);
      checkValue({name, " overflow held"}, expOvf[i], overflow);
      checkValue({name, " negative held"}, expNeg[i], negative);
    end
    checkValue("mode error clean run", 1'b0, modeError);

    // Flip the signed-mode bit while a multiply runs
    applyCtrl(opWord(opMul, 1'b0, 1'b0), 8'hFF);
    applyCtrl(opWord(opMul, 1'b1, 1'b0), 8'hFF);
    waitDone("mode change");
    checkValue("mode error set", 1'b1, modeError);
    applyCtrl(8'h00, 8'h00);
    settle();
    repeat (4) @(negedge CLK);
    checkValue("mode error sticky", 1'b1, modeError);

    $display("All checks passed");
    $finish;
  end

  // Watchdog sized from the table length
  initial
  begin
    #(timeoutNs);
    $display("Watchdog expired: the tests did not finish in time");
    $display("Checks failed");
    $fatal(1, "Run exceeded its time limit");
  end

endmodule

`default_nettype wire

/* verif/alu_properties.sv */
//////////////////////////////////////////////////////////////////////
// Concurrent assertions on the start pulse and step control
// Bound into the step sequencer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module aluProperties (
  input wire CLK,
  input wire RST,
  input wire opStart,
  input wire stepEn,
  input wire busy,
  input wire done
);

  logic seenStart;

  // Remembers that some operation was started since reset
  always_ff @(posedge CLK)
  begin
    if (RST)
      seenStart <= 1'b0;
    else if (opStart)
      seenStart <= 1'b1;
  end

  opStartPulse: assert property (@(posedge CLK) disable iff (RST) opStart |=> !opStart)
    else $error("opStart lasted more than one cycle");

  // A burst of steps only begins right after a start pulse
  stepAfterStart: assert property (@(posedge CLK) disable iff (RST)
                                   $rose(stepEn) |-> $past(opStart))
    else $error("stepEn began without an opStart in the cycle before");

  doneNotBusy: assert property (@(posedge CLK) disable iff (RST) done |-> !busy)
    else $error("done and busy high together");

  doneAfterStart: assert property (@(posedge CLK) disable iff (RST) $rose(done) |-> seenStart)
    else $error("done rose with no earlier opStart");

endmodule

bind arithSequencer aluProperties uProps (
  .CLK     (CLK),
  .RST     (RST),
  .opStart (cmd.opStart),
  .stepEn  (exec.stepEn),
  .busy    (exec.busy),
  .done    (done)
);

`default_nettype wire

/* source/aluTop.sv */
//////////////////////////////////////////////////////////////////////
// Serial arithmetic unit top level
// Plain host ports, command and execution buses, five submodules
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module aluTop (
  input  wire                    CLK,
  input  wire                    RST,
  input  wire [`ALU_CTRL_W-1:0]  ctrlIn,
  input  wire aluDataPkg::byte_t dataIn,
  output aluDataPkg::byte_t      resultOut,
  output logic                   done,
  output logic                   overflow,
  output logic                   negative,
  output logic                   modeError
);

  cmdIf  cmdBus ();
  execIf execBus ();

  commandDecoder uDecoder (
    .CLK    (CLK),
    .RST    (RST),
    .ctrlIn (ctrlIn),
    .dataIn (dataIn),
    .cmd    (cmdBus.decoder)
  );

  operandRegs uRegs (
    .CLK       (CLK),
    .RST       (RST),
    .cmd       (cmdBus.regs),
    .exec      (execBus.regs),
    .resultOut (resultOut)
  );

  arithSequencer uSequencer (
    .CLK  (CLK),
    .RST  (RST),
    .cmd  (cmdBus.seq),
    .exec (execBus.seq),
    .done (done)
  );

  addSubDatapath uDatapath (
    .CLK      (CLK),
    .RST      (RST),
    .cmd      (cmdBus.path),
    .exec     (execBus.path),
    .overflow (overflow),
    .negative (negative)
  );

  modeChangeMonitor uModeMon (
    .CLK       (CLK),
    .RST       (RST),
    .cmd       (cmdBus.mon),
    .modeError (modeError)
  );

endmodule

`default_nettype wire

/* source/modeChangeMonitor.sv */
//////////////////////////////////////////////////////////////////////
// Sticky error on a signed-mode change during an operation
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module modeChangeMonitor (
  input  wire  CLK,
  input  wire  RST,
  cmdIf.mon    cmd,
  output logic modeError
);

  logic modePrev;
  logic startPrev;

  always_ff @(posedge CLK)
  begin
    if (RST)
    begin
      modePrev  <= 1'b0;
      startPrev <= 1'b0;
      modeError <= 1'b0;
    end
    else
    begin
      modePrev  <= cmd.signedMode;
      startPrev <= cmd.start;
      // Start high in both cycles, so the mode moved mid-operation
      if (cmd.start && startPrev && cmd.signedMode != modePrev)
        modeError <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* source/addSubDatapath.sv */
//////////////////////////////////////////////////////////////////////
// Adder step: operand select, negation, 16-bit sum
// Step overflow plus the accumulated overflow and negative flags
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module addSubDatapath (
  input  wire  CLK,
  input  wire  RST,
  cmdIf.path   cmd,
  execIf.path  exec,
  output logic overflow,
  output logic negative
);
  import aluCmdPkg::*;
  import aluDataPkg::*;

  localparam int msb = `ALU_WORD_W - 1;

  word_t                 extData;
  word_t                 operand;
  word_t                 addend;
  logic                  negate;
  logic                  carryOut;
  logic [`ALU_WORD_W:0]  fullSum;

  ////////////////////////////////////////////////////////////////////
  // Operand selection
  assign extData = {{(`ALU_WORD_W - `ALU_BYTE_W){cmd.signedMode & cmd.data[`ALU_BYTE_W-1]}},
                    cmd.data};

  // Multiply adds A only where the current data bit is set
  assign operand = (cmd.op == opMul) ? (cmd.data[exec.stepIdx] ? exec.regAVal : '0)
                 : (cmd.useRegA ? exec.regAVal : extData);

  // Signed multiply: the sign bit carries negative weight
  assign negate = (cmd.op == opSub) ||
                  (cmd.op == opMul && cmd.signedMode &&
                   exec.stepIdx == `ALU_STEP_W'(`ALU_MUL_STEPS - 1));

  assign addend   = negate ? ~operand : operand;
  assign fullSum  = {1'b0, exec.regBVal} + {1'b0, addend} + {{`ALU_WORD_W{1'b0}}, negate};
  assign exec.sum = fullSum[msb:0];
  assign carryOut = fullSum[`ALU_WORD_W];

  // Signed overflow, else carry out (borrow when subtracting)
  assign exec.stepOverflow = cmd.signedMode
    ? (exec.regBVal[msb] == addend[msb]) && (fullSum[msb] != exec.regBVal[msb])
    : carryOut ^ negate;

  ////////////////////////////////////////////////////////////////////
  // Status flags
  always_ff @(posedge CLK)
  begin
    if (RST)
    begin
      overflow <= 1'b0;
      negative <= 1'b0;
    end
    else if (cmd.opStart)
      overflow <= 1'b0;
    else if (exec.stepEn)
    begin
      overflow <= overflow | exec.stepOverflow;
      negative <= cmd.signedMode & fullSum[msb];
    end
  end

endmodule

`default_nettype wire

/* source/arithSequencer.sv */
//////////////////////////////////////////////////////////////////////
// Step sequencer: step counter, busy, done flag
// One step for ADD and SUB, eight for MUL
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module arithSequencer (
  input  wire  CLK,
  input  wire  RST,
  cmdIf.seq    cmd,
  execIf.seq   exec,
  output logic done
);
  import aluCmdPkg::*;

  localparam logic [`ALU_STEP_W-1:0] lastMulIdx = `ALU_STEP_W'(`ALU_MUL_STEPS - 1);

  logic [`ALU_STEP_W-1:0] stepIdxQ;
  logic [`ALU_STEP_W-1:0] lastIdx;
  logic                   busyQ;

  assign lastIdx = (cmd.op == opMul) ? lastMulIdx : '0;

  always_ff @(posedge CLK)
  begin
    if (RST)
    begin
      busyQ    <= 1'b0;
      stepIdxQ <= '0;
      done     <= 1'b0;
    end
    else if (cmd.opStart)
    begin
      busyQ    <= 1'b1;
      stepIdxQ <= '0;
      done     <= 1'b0;
    end
    else if (busyQ)
    begin
      // Last step result lands in B on this edge
      if (stepIdxQ == lastIdx)
      begin
        busyQ <= 1'b0;
        done  <= 1'b1;
      end
      else
        stepIdxQ <= stepIdxQ + 1'b1;
    end
    else if (!cmd.start)
      done <= 1'b0;
  end

  assign exec.busy     = busyQ;
  assign exec.stepEn   = busyQ;
  assign exec.stepIdx  = stepIdxQ;
  assign exec.mulShift = busyQ & (cmd.op == opMul);

endmodule

`default_nettype wire

/* source/operandRegs.sv */
//////////////////////////////////////////////////////////////////////
// Operand registers A and B
// Byte loads, step writeback, multiply shift, read-back mux
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module operandRegs (
  input  wire               CLK,
  input  wire               RST,
  cmdIf.regs                cmd,
  execIf.regs               exec,
  output aluDataPkg::byte_t resultOut
);
  import aluDataPkg::*;

  word_t regAQ;
  word_t regBQ;

  ////////////////////////////////////////////////////////////////////
  // Register A, host load or left shift per multiply step
  always_ff @(posedge CLK)
  begin
    if (RST)
      regAQ <= '0;
    else if (cmd.loadEn && cmd.loadReg == regA)
    begin
      if (cmd.loadByte)
        regAQ[`ALU_WORD_W-1:`ALU_BYTE_W] <= cmd.data;
      else
        regAQ[`ALU_BYTE_W-1:0] <= cmd.data;
    end
    else if (exec.stepEn && exec.mulShift)
      regAQ <= {regAQ[`ALU_WORD_W-2:0], 1'b0};
  end

  // Register B, host load or accumulate
  always_ff @(posedge CLK)
  begin
    if (RST)
      regBQ <= '0;
    else if (cmd.loadEn && cmd.loadReg == regB)
    begin
      if (cmd.loadByte)
        regBQ[`ALU_WORD_W-1:`ALU_BYTE_W] <= cmd.data;
      else
        regBQ[`ALU_BYTE_W-1:0] <= cmd.data;
    end
    else if (exec.stepEn)
      regBQ <= exec.sum;
  end

  assign exec.regAVal = regAQ;
  assign exec.regBVal = regBQ;

  // Read-back byte
  always_comb
  begin
    case (cmd.readSel)
      2'b00:   resultOut = regAQ[`ALU_BYTE_W-1:0];
      2'b01:   resultOut = regAQ[`ALU_WORD_W-1:`ALU_BYTE_W];
      2'b10:   resultOut = regBQ[`ALU_BYTE_W-1:0];
      default: resultOut = regBQ[`ALU_WORD_W-1:`ALU_BYTE_W];
    endcase
  end

endmodule

`default_nettype wire

/* source/commandDecoder.sv */
//////////////////////////////////////////////////////////////////////
// Input registers and control word decode
// Load strobes, operation start pulse, latched read selector
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module commandDecoder (
  input  wire                    CLK,
  input  wire                    RST,
  input  wire [`ALU_CTRL_W-1:0]  ctrlIn,
  input  wire aluDataPkg::byte_t dataIn,
  cmdIf.decoder                  cmd
);
  import aluCmdPkg::*;
  import aluDataPkg::*;

  ctrlWord_u ctrlReg;
  byte_t     dataReg;
  logic      startPrev;
  readSel_t  readSelReg;
  logic      isLoad;

  ////////////////////////////////////////////////////////////////////
  // Sampled host inputs
  always_ff @(posedge CLK)
  begin
    if (RST)
    begin
      ctrlReg   <= '0;
      startPrev <= 1'b0;
    end
    else
    begin
      ctrlReg   <= ctrlIn;
      startPrev <= ctrlReg.arith.start;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (RST)
      dataReg <= '0;
    else
      dataReg <= dataIn;
  end

  assign isLoad = (ctrlReg.load.op == opLoad);

  // Read selector only moves on a load command with write low
  always_ff @(posedge CLK)
  begin
    if (RST)
      readSelReg <= '0;
    else if (isLoad && ctrlReg.load.start && !ctrlReg.load.write)
      readSelReg <= {ctrlReg.load.regSel, ctrlReg.load.byteSel};
  end

  ////////////////////////////////////////////////////////////////////
  // Decoded command
  assign cmd.loadEn     = isLoad & ctrlReg.load.start & ctrlReg.load.write;
  assign cmd.loadReg    = regSel_e'(ctrlReg.load.regSel);
  assign cmd.loadByte   = ctrlReg.load.byteSel;
  assign cmd.opStart    = ctrlReg.arith.start & ~startPrev & ~isLoad;
  assign cmd.op         = ctrlReg.arith.op;
  assign cmd.signedMode = ctrlReg.arith.signedMode;
  assign cmd.useRegA    = ctrlReg.arith.useRegA;
  assign cmd.start      = ctrlReg.arith.start;
  assign cmd.data       = dataReg;
  assign cmd.readSel    = readSelReg;

endmodule

`default_nettype wire

/* source/aluIfs.sv */
//////////////////////////////////////////////////////////////////////
// cmdIf: decoded host command to the rest of the unit
// execIf: step control, adder result and register values
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

interface cmdIf;
  import aluDataPkg::*;

  logic       loadEn;
  regSel_e    loadReg;
  logic       loadByte;
  logic       opStart;
  logic [1:0] op;
  logic       signedMode;
  logic       useRegA;
  logic       start;
  byte_t      data;
  readSel_t   readSel;

  modport decoder (output loadEn, loadReg, loadByte, opStart, op, signedMode,
                   useRegA, start, data, readSel);
  modport regs (input loadEn, loadReg, loadByte, data, readSel);
  modport seq (input opStart, op, start);
  modport path (input opStart, op, signedMode, useRegA, data);
  modport mon (input signedMode, start);
endinterface

interface execIf;
  import aluDataPkg::*;

  logic                   stepEn;
  logic [`ALU_STEP_W-1:0] stepIdx;
  logic                   busy;
  logic                   mulShift;
  word_t                  sum;
  logic                   stepOverflow;
  word_t                  regAVal;
  word_t                  regBVal;

  modport seq (output stepEn, stepIdx, busy, mulShift);
  modport path (input stepEn, stepIdx, regAVal, regBVal, output sum, stepOverflow);
  modport regs (input stepEn, mulShift, sum, output regAVal, regBVal);
endinterface

`default_nettype wire

/* source/aluCmdPkg.sv */
//////////////////////////////////////////////////////////////////////
// Command types: operation encoding and the two views
// of the host control word
//////////////////////////////////////////////////////////////////////

`default_nettype none

package aluCmdPkg;

  typedef enum logic [1:0] {
    opLoad = 2'b00,
    opAdd  = 2'b01,
    opSub  = 2'b10,
    opMul  = 2'b11
  } aluOp_e;

  // Register load and read-back view
  typedef struct packed {
    logic   signedMode;
    aluOp_e op;
    logic   regSel;
    logic   byteSel;
    logic   write;
    logic   start;
    logic   spare;
  } ctrlLoad_s;

  // Arithmetic view, bit 2 picks register A as operand
  typedef struct packed {
    logic       signedMode;
    aluOp_e     op;
    logic [1:0] spareHi;
    logic       useRegA;
    logic       start;
    logic       spare;
  } ctrlArith_s;

  typedef union packed {
    ctrlLoad_s  load;
    ctrlArith_s arith;
  } ctrlWord_u;

endpackage

`default_nettype wire

/* source/aluDataPkg.sv */
//////////////////////////////////////////////////////////////////////
// Data types: operand word, data byte, register select
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "alu_defines.svh"

package aluDataPkg;

  typedef logic [`ALU_WORD_W-1:0] word_t;
  typedef logic [`ALU_BYTE_W-1:0] byte_t;

  typedef enum logic {
    regA = 1'b0,
    regB = 1'b1
  } regSel_e;

  // Bit 1 picks the register, bit 0 the high byte
  typedef logic [1:0] readSel_t;

endpackage

`default_nettype wire

/* include/alu_defines.svh */
//////////////////////////////////////////////////////////////////////
// Width and step-count macros for the serial arithmetic unit
// Operand word, data byte, control word, multiply step counter
//////////////////////////////////////////////////////////////////////

`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Operand registers A and B
`define ALU_WORD_W 16

// Host data and read-back byte
`define ALU_BYTE_W 8
`define ALU_CTRL_W 8

// Shift-and-add multiply, one step per data bit
`define ALU_MUL_STEPS 8
`define ALU_STEP_W 3

`endif
